// ==== logic/lcd_config.svh ====
// widths and panel strobe timing shared by the lcd package and rtl, pulled in by `include
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// axi side
`define LCD_ADDR_W 32
`define LCD_ID_W 4

// fill repeat counter, covers a full 480x800 frame
`define LCD_CNT_W 20

// 8080 write strobe, in pclk cycles
`define LCD_WR_LOW 2
`define LCD_WR_HIGH 2

// panel reset pulse after system reset
`define LCD_RST_CYCLES 16

`endif

// ==== logic/lcd_pkg.sv ====
// types shared by the lcd blocks and the testbench, imported where the enums are needed
`default_nettype none

`include "lcd_config.svh"

package lcd_pkg;

  // kind of panel request handed from the axi slave to the sequencer
  typedef enum logic [1:0] {
    OP_CMD  = 2'd0,
    OP_DATA = 2'd1,
    OP_FILL = 2'd2
  } lcd_op_e;

  // register map, low address byte
  typedef enum logic [7:0] {
    REG_CMD        = 8'h00,
    REG_DATA       = 8'h04,
    REG_FILL_COLOR = 8'h08,
    REG_FILL_COUNT = 8'h0C,
    REG_STATUS     = 8'h10,
    REG_BL         = 8'h14
  } lcd_reg_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // bus driver phases of one write beat
  typedef enum logic [1:0] {
    B_IDLE = 2'd0,
    B_LOW  = 2'd1,
    B_HIGH = 2'd2
  } beat_state_e;

  localparam int unsigned BEAT_CYCLES = `LCD_WR_LOW + `LCD_WR_HIGH;  // cs_n low time per beat

endpackage

`default_nettype wire

// ==== logic/lcd_req_if.sv ====
// request channel from the axi slave into the sequencer, one strobe per panel operation
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

interface lcd_req_if;
  import lcd_pkg::*;

  logic                  req;    // one cycle, only while busy is low
  lcd_op_e               op;
  logic [15:0]           word;   // command, data or fill colour
  logic [`LCD_CNT_W-1:0] count;  // fill repeat count
  logic                  busy;   // panel in reset or request still running

  modport master (output req, output op, output word, output count, input busy);
  modport slave (input req, input op, input word, input count, output busy);

endinterface

`default_nettype wire

// ==== logic/lcd_beat_if.sv ====
// single write beat channel from the sequencer into the 8080 bus driver
`timescale 1ns/100ps
`default_nettype none

interface lcd_beat_if;

  logic        go;    // start strobe, only while busy is low
  logic        rs;    // 0 command, 1 data
  logic [15:0] data;
  logic        busy;  // high from the cycle after go until cs_n is released

  modport src (output go, output rs, output data, input busy);
  modport drv (input go, input rs, input data, output busy);

endinterface

`default_nettype wire

// ==== logic/lcd_axi_slave.sv ====
// single-beat axi4 register slave, turns cpu writes into panel requests and serves status reads
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module lcd_axi_slave (
  input  logic                   pclk_i,
  input  logic                   rst_n_i,
  input  logic [`LCD_ID_W-1:0]   awid_i,
  input  logic [`LCD_ADDR_W-1:0] awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic [31:0]            wdata_i,
  input  logic [3:0]             wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output logic [`LCD_ID_W-1:0]   bid_o,
  output lcd_pkg::axi_resp_e     bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  input  logic [`LCD_ID_W-1:0]   arid_i,
  input  logic [`LCD_ADDR_W-1:0] araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [`LCD_ID_W-1:0]   rid_o,
  output logic [31:0]            rdata_o,
  output lcd_pkg::axi_resp_e     rresp_o,
  output logic                   rlast_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output logic                   lcd_bl_ctr_o,
  input  logic                   init_done_i,
  lcd_req_if.master              req
);
  import lcd_pkg::*;

  lcd_reg_e              aw_reg;
  lcd_reg_e              ar_reg;
  logic                  aw_hs;
  logic                  ar_hs;
  logic                  aw_mapped;
  logic                  ar_mapped;
  logic                  wr_issue;
  lcd_op_e               wr_op;
  logic [`LCD_CNT_W-1:0] fill_cnt;
  logic [31:0]           rd_word;
  logic [15:0]           fill_color_q;
  logic                  bl_q;
  logic                  bvalid_q;
  logic                  rvalid_q;
  logic                  req_q;
  lcd_op_e               op_q;
  logic [15:0]           word_q;
  logic [`LCD_CNT_W-1:0] count_q;
  logic [`LCD_ID_W-1:0]  bid_q;
  logic [`LCD_ID_W-1:0]  rid_q;
  axi_resp_e             bresp_q;
  axi_resp_e             rresp_q;
  logic [31:0]           rdata_q;

  assign aw_reg   = lcd_reg_e'(awaddr_i[7:0]);  // upper address bits decoded outside
  assign ar_reg   = lcd_reg_e'(araddr_i[7:0]);
  assign fill_cnt = wdata_i[`LCD_CNT_W-1:0];

  // aw and w taken together, blocked by a pending b or running request
  assign awready_o = awvalid_i && wvalid_i && !bvalid_q && !req.busy;
  assign wready_o  = awready_o;
  assign aw_hs     = awready_o;
  assign arready_o = !rvalid_q;
  assign ar_hs     = arvalid_i && !rvalid_q;

  always_comb begin
    aw_mapped = 1'b1;
    wr_issue  = 1'b0;
    wr_op     = OP_CMD;
    case (aw_reg)
      REG_CMD: wr_issue = 1'b1;
      REG_DATA: begin
        wr_issue = 1'b1;
        wr_op    = OP_DATA;
      end
      REG_FILL_COUNT: begin
        wr_issue = (fill_cnt != '0);  // zero count starts nothing
        wr_op    = OP_FILL;
      end
      REG_FILL_COLOR, REG_STATUS, REG_BL: ;  // register side effects only
      default: aw_mapped = 1'b0;
    endcase
  end

  always_comb begin
    ar_mapped = 1'b1;
    rd_word   = '0;
    case (ar_reg)
      REG_STATUS: rd_word = {30'd0, init_done_i, req.busy};
      REG_BL:     rd_word = {31'd0, bl_q};
      REG_CMD, REG_DATA, REG_FILL_COLOR, REG_FILL_COUNT: ;  // write-only, read as zero
      default: ar_mapped = 1'b0;
    endcase
  end

  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q     <= 1'b0;
      rvalid_q     <= 1'b0;
      req_q        <= 1'b0;
      bl_q         <= 1'b0;
      fill_color_q <= '0;
    end else begin
      req_q <= aw_hs && wr_issue;
      if (aw_hs) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
      if (aw_hs && aw_reg == REG_FILL_COLOR) begin
        fill_color_q <= wdata_i[15:0];
      end
      if (aw_hs && aw_reg == REG_BL) begin
        bl_q <= wdata_i[0];
      end
    end
  end

  always_ff @(posedge pclk_i) begin
    if (aw_hs) begin
      bid_q   <= awid_i;
      bresp_q <= aw_mapped ? RESP_OKAY : RESP_DECERR;
      op_q    <= wr_op;
      word_q  <= (wr_op == OP_FILL) ? fill_color_q : wdata_i[15:0];
      count_q <= fill_cnt;
    end
    if (ar_hs) begin
      rid_q   <= arid_i;
      rdata_q <= rd_word;
      rresp_q <= ar_mapped ? RESP_OKAY : RESP_DECERR;
    end
  end

  assign req.req      = req_q;
  assign req.op       = op_q;
  assign req.word     = word_q;
  assign req.count    = count_q;
  assign bid_o        = bid_q;
  assign bresp_o      = bresp_q;
  assign bvalid_o     = bvalid_q;
  assign rid_o        = rid_q;
  assign rdata_o      = rdata_q;
  assign rresp_o      = rresp_q;
  assign rlast_o      = 1'b1;  // every read is a single beat
  assign rvalid_o     = rvalid_q;
  assign lcd_bl_ctr_o = bl_q;

  // write response held with its id until the master takes it
  a_b_hold: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bid_o))
    else $error("bvalid dropped or bid changed before bready");

endmodule

`default_nettype wire

// ==== logic/lcd_seq.sv ====
// panel reset timing and request sequencing, expands command, data and fill requests into beats
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module lcd_seq (
  input  logic      pclk_i,
  input  logic      rst_n_i,
  lcd_req_if.slave  req,
  lcd_beat_if.src   beat,
  output logic      lcd_rst_o,
  output logic      init_done_o
);
  import lcd_pkg::*;

  localparam int RST_W = $clog2(`LCD_RST_CYCLES + 1);

  logic [RST_W-1:0]      rst_cnt_q;
  logic                  init_done_q;
  logic                  active_q;
  logic [`LCD_CNT_W-1:0] rem_q;      // beats not yet started
  logic                  rs_q;
  logic [15:0]           data_q;
  logic                  last_done;

  // panel reset pulse, counted once after system reset
  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_cnt_q   <= '0;
      init_done_q <= 1'b0;
    end else if (!init_done_q) begin
      rst_cnt_q <= rst_cnt_q + 1'b1;
      if (rst_cnt_q == RST_W'(`LCD_RST_CYCLES - 1)) begin
        init_done_q <= 1'b1;
      end
    end
  end

  assign last_done = (rem_q == '0) && !beat.busy;  // final beat off the bus

  // next beat as soon as the driver is idle
  assign beat.go   = active_q && (rem_q != '0) && !beat.busy;
  assign beat.rs   = rs_q;
  assign beat.data = data_q;
  assign req.busy  = !init_done_q || (active_q && !last_done);

  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      rem_q    <= '0;
    end else if (req.req) begin
      active_q <= 1'b1;
      rem_q    <= (req.op == OP_FILL) ? req.count : {{(`LCD_CNT_W-1){1'b0}}, 1'b1};
    end else if (beat.go) begin
      rem_q <= rem_q - 1'b1;
    end else if (active_q && last_done) begin
      active_q <= 1'b0;
    end
  end

  // word and register select kept for every beat of the request
  always_ff @(posedge pclk_i) begin
    if (req.req) begin
      rs_q   <= (req.op != OP_CMD);
      data_q <= req.word;
    end
  end

  assign lcd_rst_o   = init_done_q;  // active low panel reset
  assign init_done_o = init_done_q;

  // go only into an idle driver, which must take it on the next cycle
  a_go_idle: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    beat.go |-> !beat.busy ##1 beat.busy)
    else $error("beat go raised while bus driver busy or not taken");

endmodule

`default_nettype wire

// ==== logic/lcd_bus_driver.sv ====
// 8080 write strobe generator, drives cs_n, rs, wr_n and the data bus for each beat
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module lcd_bus_driver (
  input  logic        pclk_i,
  input  logic        rst_n_i,
  lcd_beat_if.drv     beat,
  output logic        lcd_cs_o,
  output logic        lcd_rs_o,
  output logic        lcd_wr_o,
  output logic [15:0] lcd_data_o,
  output logic        lcd_data_oe_o
);
  import lcd_pkg::*;

  localparam int PH_W = $clog2(BEAT_CYCLES);

  beat_state_e     state_q;
  logic [PH_W-1:0] phase_q;  // cycle within the beat
  logic            rs_q;
  logic [15:0]     data_q;

  always_ff @(posedge pclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= B_IDLE;
      phase_q <= '0;
    end else begin
      case (state_q)
        B_IDLE: begin
          phase_q <= '0;
          if (beat.go) begin
            state_q <= B_LOW;
          end
        end
        B_LOW: begin
          phase_q <= phase_q + 1'b1;
          if (phase_q == PH_W'(`LCD_WR_LOW - 1)) begin
            state_q <= B_HIGH;  // rising wr_n, panel latches here
          end
        end
        B_HIGH: begin
          phase_q <= phase_q + 1'b1;
          if (phase_q == PH_W'(BEAT_CYCLES - 1)) begin
            state_q <= B_IDLE;
          end
        end
        default: state_q <= B_IDLE;
      endcase
    end
  end

  always_ff @(posedge pclk_i) begin
    if (beat.go) begin
      rs_q   <= beat.rs;
      data_q <= beat.data;
    end
  end

  assign beat.busy     = (state_q != B_IDLE);
  assign lcd_cs_o      = (state_q == B_IDLE);  // active low
  assign lcd_wr_o      = (state_q != B_LOW);   // active low
  assign lcd_rs_o      = rs_q;
  assign lcd_data_o    = data_q;
  assign lcd_data_oe_o = !lcd_cs_o;

  // wr_n low only under cs_n, and cs_n still low when wr_n rises
  a_wr_in_cs: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    !lcd_wr_o |-> !lcd_cs_o ##1 !lcd_cs_o)
    else $error("wr_n strobe outside chip select");

endmodule

`default_nettype wire

// ==== logic/lcd_top.sv ====
// lcd subsystem top, axi4 register port in and 8080 panel pins out, pad muxing left to chip top
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module lcd_top (
  input  logic                   pclk_i,
  input  logic                   rst_n_i,
  input  logic [`LCD_ID_W-1:0]   awid_i,
  input  logic [`LCD_ADDR_W-1:0] awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic [31:0]            wdata_i,
  input  logic [3:0]             wstrb_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  output logic [`LCD_ID_W-1:0]   bid_o,
  output lcd_pkg::axi_resp_e     bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  input  logic [`LCD_ID_W-1:0]   arid_i,
  input  logic [`LCD_ADDR_W-1:0] araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic [`LCD_ID_W-1:0]   rid_o,
  output logic [31:0]            rdata_o,
  output lcd_pkg::axi_resp_e     rresp_o,
  output logic                   rlast_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output logic                   lcd_rst_o,      // panel reset, active low
  output logic                   lcd_cs_o,
  output logic                   lcd_rs_o,       // 0 command, 1 data
  output logic                   lcd_wr_o,
  output logic [15:0]            lcd_data_o,
  output logic                   lcd_data_oe_o,  // pad output enable
  output logic                   lcd_bl_ctr_o
);

  logic init_done;

  lcd_req_if  u_req_if ();
  lcd_beat_if u_beat_if ();

  lcd_axi_slave u_axi_slave (
    .pclk_i       (pclk_i),
    .rst_n_i      (rst_n_i),
    .awid_i       (awid_i),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bid_o        (bid_o),
    .bresp_o      (bresp_o),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .arid_i       (arid_i),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rid_o        (rid_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rlast_o      (rlast_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .lcd_bl_ctr_o (lcd_bl_ctr_o),
    .init_done_i  (init_done),
    .req          (u_req_if)
  );

  lcd_seq u_seq (
    .pclk_i      (pclk_i),
    .rst_n_i     (rst_n_i),
    .req         (u_req_if),
    .beat        (u_beat_if),
    .lcd_rst_o   (lcd_rst_o),
    .init_done_o (init_done)
  );

  lcd_bus_driver u_bus_driver (
    .pclk_i        (pclk_i),
    .rst_n_i       (rst_n_i),
    .beat          (u_beat_if),
    .lcd_cs_o      (lcd_cs_o),
    .lcd_rs_o      (lcd_rs_o),
    .lcd_wr_o      (lcd_wr_o),
    .lcd_data_o    (lcd_data_o),
    .lcd_data_oe_o (lcd_data_oe_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_lcd_top.sv ====
// self-checking testbench for lcd_top, drives the axi port and checks panel beats and responses
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module tb_lcd_top;
  import lcd_pkg::*;

  localparam int ID_W = `LCD_ID_W;
  localparam int MAX_FILL = 8;
  localparam int TOTAL_BEATS = 3 + MAX_FILL;  // cmd, data, held data and the longest fill
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * (`LCD_WR_LOW + `LCD_WR_HIGH) + 200;

  logic                   pclk_i;
  logic                   rst_n_i;
  logic [ID_W-1:0]        awid_i;
  logic [`LCD_ADDR_W-1:0] awaddr_i;
  logic                   awvalid_i;
  logic                   awready_o;
  logic [31:0]            wdata_i;
  logic [3:0]             wstrb_i;
  logic                   wvalid_i;
  logic                   wready_o;
  logic [ID_W-1:0]        bid_o;
  axi_resp_e              bresp_o;
  logic                   bvalid_o;
  logic                   bready_i;
  logic [ID_W-1:0]        arid_i;
  logic [`LCD_ADDR_W-1:0] araddr_i;
  logic                   arvalid_i;
  logic                   arready_o;
  logic [ID_W-1:0]        rid_o;
  logic [31:0]            rdata_o;
  axi_resp_e              rresp_o;
  logic                   rlast_o;
  logic                   rvalid_o;
  logic                   rready_i;
  logic                   lcd_rst_o;
  logic                   lcd_cs_o;
  logic                   lcd_rs_o;
  logic                   lcd_wr_o;
  logic [15:0]            lcd_data_o;
  logic                   lcd_data_oe_o;
  logic                   lcd_bl_ctr_o;

  logic [16:0]     exp_q[$];  // {rs, data} per beat
  logic [16:0]     got_q[$];
  logic [16:0]     exp_beat;
  logic [16:0]     got_beat;
  logic            cmp_valid;
  logic [ID_W-1:0] exp_bid;
  logic [ID_W-1:0] exp_rid;
  axi_resp_e       exp_bresp;
  axi_resp_e       exp_rresp;
  logic [31:0]     exp_rdata;
  string           test_name;
  int              errors;
  int              err_start;
  int              tests_run;
  int              tests_bad;
  int              exp_cnt;
  int              got_cnt;

  lcd_top dut (.*);

  always #4 pclk_i = ~pclk_i;

  // panel latches on the rising wr_n edge
  always @(posedge lcd_wr_o) begin
    if (rst_n_i) begin
      got_q.push_back({lcd_rs_o, lcd_data_o});
      got_cnt++;
    end
  end

  // pair up beats away from the rising clock edge
  always @(negedge pclk_i) begin
    cmp_valid = 1'b0;
    if (got_q.size() != 0 && exp_q.size() != 0) begin
      got_beat  = got_q.pop_front();
      exp_beat  = exp_q.pop_front();
      cmp_valid = 1'b1;
    end
  end

  a_beat: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    cmp_valid |-> got_beat == exp_beat)
    else begin
      $display("FAIL %s beat: expected rs %0b data %h, actual rs %0b data %h", test_name,
               exp_beat[16], exp_beat[15:0], got_beat[16], got_beat[15:0]);
      errors++;
    end

  a_bresp: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    bvalid_o |-> bid_o == exp_bid && bresp_o == exp_bresp)
    else begin
      $display("FAIL %s bresp: expected id %h %s, actual id %h %s", test_name,
               exp_bid, exp_bresp.name(), bid_o, bresp_o.name());
      errors++;
    end

  // read data only defined for mapped offsets
  a_rresp: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    rvalid_o |-> rid_o == exp_rid && rresp_o == exp_rresp && rlast_o &&
                 (exp_rresp != RESP_OKAY || rdata_o == exp_rdata))
    else begin
      $display("FAIL %s read: expected id %h %s data %h last 1, actual id %h %s data %h last %0b",
               test_name, exp_rid, exp_rresp.name(), exp_rdata, rid_o, rresp_o.name(), rdata_o,
               rlast_o);
      errors++;
    end

  a_b_hold: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bid_o) && $stable(bresp_o))
    else begin
      $display("%s: write response dropped or changed while bready was low", test_name);
      errors++;
    end

  a_r_hold: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rid_o) && $stable(rdata_o) && $stable(rresp_o))
    else begin
      $display("%s: read response dropped or changed while rready was low", test_name);
      errors++;
    end

  a_no_accept: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    bvalid_o |-> !awready_o)
    else begin
      $display("%s: write accepted while a write response was pending", test_name);
      errors++;
    end

  // aw and w accepted in the same cycle
  a_wready: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    wready_o == awready_o)
    else begin
      $display("FAIL %s wready: expected %0b, actual %0b", test_name,
               $sampled(awready_o), $sampled(wready_o));
      errors++;
    end

  a_arready: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    !rvalid_o |-> arready_o)
    else begin
      $display("%s: arready low with no read response pending", test_name);
      errors++;
    end

  // pad driven exactly while chip select is active
  a_data_oe: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    lcd_data_oe_o == !lcd_cs_o)
    else begin
      $display("FAIL %s data_oe: expected %0b, actual %0b", test_name,
               !$sampled(lcd_cs_o), $sampled(lcd_data_oe_o));
      errors++;
    end

  a_quiet_reset: assert property (@(posedge pclk_i) disable iff (!rst_n_i)
    !lcd_rst_o |-> lcd_wr_o && lcd_cs_o)
    else begin
      $display("%s: panel strobed while still held in reset", test_name);
      errors++;
    end

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    a_eq: assert (exp == act) else begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = errors;
    exp_cnt   = 0;
    got_cnt   = 0;
  endtask

  task automatic finish_test();
    #2;  // clear of the compare process
    check_eq("beat count", exp_cnt, got_cnt);
    exp_q.delete();
    got_q.delete();
    tests_run++;
    if (errors != err_start) begin
      tests_bad++;
      $display("%s: %0d errors", test_name, errors - err_start);
    end else begin
      $display("%s: ok", test_name);
    end
  endtask

  task automatic push_exp(input logic [16:0] b);
    exp_q.push_back(b);
    exp_cnt++;
  endtask

  // wait for the expected beats, then long enough for a stray extra one to show
  task automatic drain();
    while (got_cnt < exp_cnt) @(negedge pclk_i);
    repeat (`LCD_WR_LOW + `LCD_WR_HIGH + 2) @(negedge pclk_i);
  endtask

  task automatic axi_write(input logic [7:0] off, input logic [31:0] data,
                           input axi_resp_e resp, input int hold);
    @(negedge pclk_i);
    awid_i    = ID_W'($urandom_range(2**ID_W - 1, 0));
    exp_bid   = awid_i;
    exp_bresp = resp;
    awaddr_i  = {24'h400000, off};
    wdata_i   = data;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    #1;
    while (!awready_o) begin
      @(negedge pclk_i);
      #1;
    end
    @(negedge pclk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    while (!bvalid_o) @(negedge pclk_i);
    repeat (hold) begin
      awaddr_i  = {24'h400000, REG_STATUS};  // next write offered while b is pending
      awvalid_i = 1'b1;
      wvalid_i  = 1'b1;
      @(negedge pclk_i);
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b1;
    @(negedge pclk_i);
    bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] off, input logic [31:0] data,
                          input axi_resp_e resp, input int hold);
    @(negedge pclk_i);
    arid_i    = ID_W'($urandom_range(2**ID_W - 1, 0));
    exp_rid   = arid_i;
    exp_rdata = data;
    exp_rresp = resp;
    araddr_i  = {24'h400000, off};
    arvalid_i = 1'b1;
    while (!arready_o) @(negedge pclk_i);
    @(negedge pclk_i);
    arvalid_i = 1'b0;
    while (!rvalid_o) @(negedge pclk_i);
    repeat (hold) @(negedge pclk_i);
    rready_i = 1'b1;
    @(negedge pclk_i);
    rready_i = 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge pclk_i);
    $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int          cycles;
    int          n;
    logic [31:0] w;
    void'($urandom(30));
    pclk_i    = 1'b0;
    rst_n_i   = 1'b0;
    awid_i    = '0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = 4'hF;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    arid_i    = '0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    exp_bresp = RESP_OKAY;
    exp_rresp = RESP_OKAY;
    cmp_valid = 1'b0;
    errors    = 0;
    tests_run = 0;
    tests_bad = 0;
    repeat (3) @(negedge pclk_i);

    start_test("reset");
    rst_n_i = 1'b1;
    check_eq("panel reset after release", 32'd0, {31'd0, lcd_rst_o});
    cycles = 0;
    while (!lcd_rst_o) begin
      @(negedge pclk_i);
      cycles++;
    end
    check_eq("panel reset cycles", `LCD_RST_CYCLES, cycles);
    axi_read(REG_STATUS, 32'h2, RESP_OKAY, 0);  // done, idle
    finish_test();

    start_test("command");
    w = $urandom();
    push_exp({1'b0, w[15:0]});
    axi_write(REG_CMD, w, RESP_OKAY, 0);
    drain();
    finish_test();

    start_test("data");
    w = $urandom();
    push_exp({1'b1, w[15:0]});
    axi_write(REG_DATA, w, RESP_OKAY, 0);
    drain();
    finish_test();

    start_test("fill");
    w = $urandom();
    n = $urandom_range(MAX_FILL, 1);
    axi_write(REG_FILL_COLOR, w, RESP_OKAY, 0);
    repeat (n) push_exp({1'b1, w[15:0]});
    axi_write(REG_FILL_COUNT, 32'(n), RESP_OKAY, 0);
    axi_read(REG_STATUS, 32'h3, RESP_OKAY, 0);
    drain();
    axi_read(REG_STATUS, 32'h2, RESP_OKAY, 0);
    axi_write(REG_FILL_COUNT, 32'h0, RESP_OKAY, 0);  // zero count starts nothing
    drain();
    axi_read(REG_STATUS, 32'h2, RESP_OKAY, 0);
    finish_test();

    start_test("backlight_decode");
    axi_write(REG_BL, 32'h1, RESP_OKAY, 0);
    check_eq("backlight on", 32'h1, {31'd0, lcd_bl_ctr_o});
    axi_read(REG_BL, 32'h1, RESP_OKAY, 0);
    axi_write(REG_BL, 32'h0, RESP_OKAY, 0);
    check_eq("backlight off", 32'h0, {31'd0, lcd_bl_ctr_o});
    axi_read(REG_BL, 32'h0, RESP_OKAY, 0);
    axi_write(REG_STATUS, $urandom(), RESP_OKAY, 0);
    axi_write(8'h20, $urandom(), RESP_DECERR, 0);
    axi_read(8'h40, 32'h0, RESP_DECERR, 0);
    drain();
    finish_test();

    start_test("backpressure");
    w = $urandom();
    push_exp({1'b1, w[15:0]});
    axi_write(REG_DATA, w, RESP_OKAY, $urandom_range(4, 1));
    drain();
    axi_read(REG_BL, 32'h0, RESP_OKAY, $urandom_range(4, 1));
    finish_test();

    $display("summary: %0d tests run, %0d with errors, %0d errors", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/lcd_pkg.sv
logic/lcd_req_if.sv
logic/lcd_beat_if.sv
logic/lcd_axi_slave.sv
logic/lcd_seq.sv
logic/lcd_bus_driver.sv
logic/lcd_top.sv
test/tb_lcd_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lcd_top
RTL_TOP   ?= lcd_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
